/* hdl/spi_pkg.sv */
package spi_pkg;

  // Register offsets on the internal register bus
  localparam logic [4:0] REG_RX0     = 5'h00;
  localparam logic [4:0] REG_RX1     = 5'h04;
  localparam logic [4:0] REG_TX0     = 5'h08;
  localparam logic [4:0] REG_TX1     = 5'h0C;
  localparam logic [4:0] REG_CTRL    = 5'h10;
  localparam logic [4:0] REG_DIVIDER = 5'h14;
  localparam logic [4:0] REG_SS      = 5'h18;

  // Serial flash read opcode
  localparam logic [7:0] FLASH_READ_OP = 8'h03;

  // Register bus request, held until ack
  typedef struct packed {
    logic [4:0]  adr;
    logic [31:0] dat;
    logic [3:0]  sel;
    logic        we;
    logic        stb;
  } reg_req_t;

  // Register bus response
  typedef struct packed {
    logic [31:0] dat;
    logic        ack;
  } reg_rsp_t;

  // CTRL register, go_bsy at bit 8 and ie at bit 12
  typedef struct packed {
    logic [18:0] spare_hi;
    logic        ie;
    logic [2:0]  spare_mid;
    logic        go_bsy;
    logic        spare_lo;
    logic [6:0]  char_len;  // 0 selects 64 bits
  } ctrl_reg_t;

  // Flash command fields, opcode goes out first
  typedef struct packed {
    logic [7:0]  opcode;
    logic [23:0] addr;
  } flash_cmd_t;

  // Transmit word, raw for the register file
  typedef union packed {
    logic [31:0] raw;
    flash_cmd_t  cmd;
  } cmd_word_u;

endpackage

/* hdl/spi_shifter.sv */
`timescale 1ns/1ns

module spi_shifter (
  input  logic        clock,
  input  logic        reset,
  input  logic        start_i,
  input  logic [63:0] tx_i,
  input  logic [6:0]  len_i,
  input  logic [15:0] divider_i,
  input  logic        miso_i,
  output logic        busy_o,
  output logic        done_o,
  output logic [63:0] rx_o,
  output logic        sck_o,
  output logic        mosi_o
);

  logic [6:0]  nbits;
  logic [15:0] div_q;
  logic [15:0] cnt_q;
  logic [6:0]  bits_q;
  logic        busy_q;
  logic        sck_q;
  logic        done_q;
  logic [63:0] tx_q;
  logic [63:0] rx_q;
  logic        load;
  logic        half_end;

  // Length 0 and 64 both give a full 64-bit frame
  assign nbits    = (len_i[5:0] == 6'd0) ? 7'd64 : {1'b0, len_i[5:0]};
  assign load     = start_i && !busy_q;
  assign half_end = busy_q && (cnt_q == 16'd0);

  // Divider, SCK phase and bit counter
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      busy_q <= 1'b0;
      sck_q  <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= 16'd0;
      div_q  <= 16'd0;
      bits_q <= 7'd0;
    end else begin
      done_q <= 1'b0;
      if (load) begin
        busy_q <= 1'b1;
        sck_q  <= 1'b0;
        cnt_q  <= divider_i;
        div_q  <= divider_i;
        bits_q <= nbits;
      end else if (half_end) begin
        cnt_q <= div_q;
        sck_q <= ~sck_q;
        // Falling edge closes one bit
        if (sck_q) begin
          bits_q <= bits_q - 7'd1;
          if (bits_q == 7'd1) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
          end
        end
      end else if (busy_q) begin
        cnt_q <= cnt_q - 16'd1;
      end
    end
  end

  // Shift registers
  always_ff @(posedge clock) begin
    if (load) begin
      // Align bit len-1 to the MSB
      tx_q <= tx_i << (7'd64 - nbits);
      rx_q <= '0;
    end else if (half_end) begin
      if (!sck_q) begin
        // Mode 0 samples on rising SCK
        rx_q <= {rx_q[62:0], miso_i};
      end else begin
        tx_q <= {tx_q[62:0], 1'b0};
      end
    end
  end

  assign busy_o = busy_q;
  assign done_o = done_q;
  assign rx_o   = rx_q;
  assign sck_o  = sck_q;
  // MOSI quiet while idle
  assign mosi_o = busy_q & tx_q[63];

endmodule

/* hdl/spi_regs.sv */
`timescale 1ns/1ns

module spi_regs
  import spi_pkg::*;
#(
  parameter int SS_NUM = 8
) (
  input  logic              clock,
  input  logic              reset,
  input  reg_req_t          req_i,
  output reg_rsp_t          rsp_o,
  input  logic              miso_i,
  output logic              sck_o,
  output logic              mosi_o,
  output logic [SS_NUM-1:0] ss_o,
  output logic              irq_o
);

  logic [31:0]       tx0_q;
  cmd_word_u         tx1_q;
  logic [63:0]       rx_q;
  ctrl_reg_t         ctrl_q;
  ctrl_reg_t         ctrl_n;
  logic [15:0]       divider_q;
  logic [31:0]       div_new;
  logic [SS_NUM-1:0] ss_q;
  logic [31:0]       ss_ext;
  logic [31:0]       ss_new;
  logic              irq_q;
  logic              ack_q;
  logic              wr_en;
  logic              xfer_busy;
  logic              sh_start;
  logic              sh_busy;
  logic              sh_done;
  logic [63:0]       sh_rx;
  logic [31:0]       rd_dat;

  // Byte lane merge
  function automatic logic [31:0] merge_bytes(logic [31:0] old_v, logic [31:0] new_v,
                                              logic [3:0] sel);
    logic [31:0] res;
    res = old_v;
    for (int i = 0; i < 4; i++) begin
      if (sel[i]) res[8*i +: 8] = new_v[8*i +: 8];
    end
    return res;
  endfunction

  // Write once per request, on the cycle before ack
  assign wr_en     = req_i.stb && req_i.we && !ack_q;
  assign xfer_busy = ctrl_q.go_bsy | sh_busy;

  always_comb begin
    ss_ext             = '0;
    ss_ext[SS_NUM-1:0] = ss_q;
  end

  assign ss_new   = merge_bytes(ss_ext, req_i.dat, req_i.sel);
  // DIVIDER keeps only its low 16 bits
  assign div_new  = merge_bytes({16'd0, divider_q}, req_i.dat, req_i.sel);
  assign ctrl_n   = ctrl_reg_t'(merge_bytes(ctrl_q, req_i.dat, req_i.sel));
  // Start only from idle
  assign sh_start = wr_en && (req_i.adr == REG_CTRL) && ctrl_n.go_bsy && !xfer_busy;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      ctrl_q    <= '0;
      divider_q <= 16'd0;
      ss_q      <= '0;
      irq_q     <= 1'b0;
      ack_q     <= 1'b0;
    end else begin
      ack_q <= req_i.stb && !ack_q;
      if (wr_en) begin
        case (req_i.adr)
          REG_CTRL: begin
            ctrl_q.char_len <= ctrl_n.char_len;
            ctrl_q.ie       <= ctrl_n.ie;
            if (!xfer_busy) ctrl_q.go_bsy <= ctrl_n.go_bsy;
            irq_q <= 1'b0;
          end
          REG_DIVIDER: divider_q <= div_new[15:0];
          REG_SS:      ss_q      <= ss_new[SS_NUM-1:0];
          default: ;
        endcase
      end
      // End of transfer
      if (sh_done) begin
        ctrl_q.go_bsy <= 1'b0;
        if (ctrl_q.ie) irq_q <= 1'b1;
      end
    end
  end

  // Data words
  always_ff @(posedge clock) begin
    if (wr_en && req_i.adr == REG_TX0) tx0_q <= merge_bytes(tx0_q, req_i.dat, req_i.sel);
    if (wr_en && req_i.adr == REG_TX1) tx1_q.raw <= merge_bytes(tx1_q.raw, req_i.dat, req_i.sel);
    if (sh_done) rx_q <= sh_rx;
  end

  // Read mux, live even without stb
  always_comb begin
    case (req_i.adr)
      REG_RX0:     rd_dat = rx_q[31:0];
      REG_RX1:     rd_dat = rx_q[63:32];
      REG_TX0:     rd_dat = tx0_q;
      REG_TX1:     rd_dat = tx1_q.raw;
      REG_CTRL:    rd_dat = ctrl_q;
      REG_DIVIDER: rd_dat = {16'd0, divider_q};
      REG_SS:      rd_dat = ss_ext;
      default:     rd_dat = 32'd0;
    endcase
  end

  assign rsp_o.dat = rd_dat;
  assign rsp_o.ack = ack_q;
  // Set bit pulls its select low
  assign ss_o      = ~ss_q;
  assign irq_o     = irq_q;

  spi_shifter i_spi_shifter (
    .clock     (clock),
    .reset     (reset),
    .start_i   (sh_start),
    .tx_i      ({tx1_q.raw, tx0_q}),
    .len_i     (ctrl_n.char_len),
    .divider_i (divider_q),
    .miso_i    (miso_i),
    .busy_o    (sh_busy),
    .done_o    (sh_done),
    .rx_o      (sh_rx),
    .sck_o     (sck_o),
    .mosi_o    (mosi_o)
  );

endmodule

/* hdl/xip_sequencer.sv */
`timescale 1ns/1ns

module xip_sequencer
  import spi_pkg::*;
#(
  parameter logic [31:0] FLASH_BASE  = 32'h3000_0000,
  parameter logic [31:0] FLASH_END   = 32'h3fff_ffff,
  parameter logic [31:0] SPI_BASE    = 32'h1000_1000,
  parameter logic [31:0] SPI_END     = 32'h1000_1fff,
  parameter int          XIP_DIVIDER = 1
) (
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] paddr_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [31:0] pwdata_i,
  input  logic [3:0]  pstrb_i,
  output logic        pready_o,
  output logic [31:0] prdata_o,
  output logic        pslverr_o,
  output reg_req_t    req_o,
  input  reg_rsp_t    rsp_i
);

  // Flash read steps
  localparam logic [3:0] ST_IDLE = 4'd0;
  localparam logic [3:0] ST_CMD  = 4'd1;
  localparam logic [3:0] ST_DIV  = 4'd2;
  localparam logic [3:0] ST_SS   = 4'd3;
  localparam logic [3:0] ST_GO   = 4'd4;
  localparam logic [3:0] ST_POLL = 4'd5;
  localparam logic [3:0] ST_CLR  = 4'd6;
  localparam logic [3:0] ST_RX   = 4'd7;
  localparam logic [3:0] ST_DONE = 4'd8;

  logic [3:0]  state_q;
  logic [31:0] data_q;
  logic        access;
  logic        flash_hit;
  logic        spi_hit;
  logic        bad_acc;
  cmd_word_u   cmd;
  ctrl_reg_t   ctrl_go;
  ctrl_reg_t   ctrl_rd;
  reg_req_t    apb_req;
  reg_req_t    seq_req;

  // Address windows
  assign access    = psel_i && penable_i;
  assign flash_hit = (paddr_i >= FLASH_BASE) && (paddr_i <= FLASH_END);
  assign spi_hit   = (paddr_i >= SPI_BASE) && (paddr_i <= SPI_END);
  // Flash writes and stray addresses
  assign bad_acc   = access && !spi_hit && !(flash_hit && !pwrite_i);

  // Read command word
  always_comb begin
    cmd.cmd.opcode = FLASH_READ_OP;
    cmd.cmd.addr   = paddr_i[23:0];
  end

  // Start a 64-bit frame
  always_comb begin
    ctrl_go          = '0;
    ctrl_go.go_bsy   = 1'b1;
    ctrl_go.char_len = 7'd64;
  end

  // Live CTRL view during the poll
  assign ctrl_rd = ctrl_reg_t'(rsp_i.dat);

  // Direct register access
  always_comb begin
    apb_req.adr = paddr_i[4:0];
    apb_req.dat = pwdata_i;
    apb_req.sel = pstrb_i;
    apb_req.we  = pwrite_i;
    apb_req.stb = access && spi_hit;
  end

  // Request per step
  always_comb begin
    seq_req     = '0;
    seq_req.sel = 4'hF;
    seq_req.we  = 1'b1;
    seq_req.stb = 1'b1;
    case (state_q)
      ST_CMD: begin
        seq_req.adr = REG_TX1;
        seq_req.dat = cmd.raw;
      end
      ST_DIV: begin
        seq_req.adr = REG_DIVIDER;
        seq_req.dat = 32'(XIP_DIVIDER);
      end
      ST_SS: begin
        seq_req.adr = REG_SS;
        seq_req.dat = 32'd1;
      end
      ST_GO: begin
        seq_req.adr = REG_CTRL;
        seq_req.dat = ctrl_go;
      end
      ST_POLL: begin
        // No strobe, just watch go_bsy
        seq_req.adr = REG_CTRL;
        seq_req.we  = 1'b0;
        seq_req.stb = 1'b0;
      end
      ST_CLR: begin
        seq_req.adr = REG_SS;
        seq_req.dat = 32'd0;
      end
      ST_RX: begin
        seq_req.adr = REG_RX0;
        seq_req.we  = 1'b0;
      end
      default: begin
        seq_req.we  = 1'b0;
        seq_req.stb = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: if (access && flash_hit && !pwrite_i) state_q <= ST_CMD;
        ST_CMD:  if (rsp_i.ack) state_q <= ST_DIV;
        ST_DIV:  if (rsp_i.ack) state_q <= ST_SS;
        ST_SS:   if (rsp_i.ack) state_q <= ST_GO;
        ST_GO:   if (rsp_i.ack) state_q <= ST_POLL;
        ST_POLL: if (!ctrl_rd.go_bsy) state_q <= ST_CLR;
        ST_CLR:  if (rsp_i.ack) state_q <= ST_RX;
        ST_RX:   if (rsp_i.ack) state_q <= ST_DONE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Flash word for the APB read
  always_ff @(posedge clock) begin
    if (state_q == ST_RX && rsp_i.ack) data_q <= rsp_i.dat;
  end

  assign req_o = (state_q == ST_IDLE) ? apb_req : seq_req;

  // APB completion
  always_comb begin
    pready_o  = 1'b0;
    prdata_o  = 32'd0;
    pslverr_o = 1'b0;
    if (state_q != ST_IDLE) begin
      pready_o = (state_q == ST_DONE);
      prdata_o = data_q;
    end else if (spi_hit) begin
      pready_o = rsp_i.ack;
      prdata_o = rsp_i.dat;
    end else if (bad_acc) begin
      pready_o  = 1'b1;
      pslverr_o = 1'b1;
    end
  end

endmodule

/* hdl/spi_apb_top.sv */
`timescale 1ns/1ns

module spi_apb_top
  import spi_pkg::*;
#(
  parameter logic [31:0] FLASH_BASE  = 32'h3000_0000,
  parameter logic [31:0] FLASH_END   = 32'h3fff_ffff,
  parameter logic [31:0] SPI_BASE    = 32'h1000_1000,
  parameter logic [31:0] SPI_END     = 32'h1000_1fff,
  parameter int          SS_NUM      = 8,
  parameter int          XIP_DIVIDER = 1
) (
  input  logic              clock,
  input  logic              reset,
  input  logic [31:0]       paddr_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [31:0]       pwdata_i,
  input  logic [3:0]        pstrb_i,
  output logic              pready_o,
  output logic [31:0]       prdata_o,
  output logic              pslverr_o,
  output logic              spi_sck_o,
  output logic [SS_NUM-1:0] spi_ss_o,
  output logic              spi_mosi_o,
  input  logic              spi_miso_i,
  output logic              irq_o
);

  // Internal register bus
  reg_req_t reg_req;
  reg_rsp_t reg_rsp;

  // APB decode and flash reads
  xip_sequencer #(
    .FLASH_BASE  (FLASH_BASE),
    .FLASH_END   (FLASH_END),
    .SPI_BASE    (SPI_BASE),
    .SPI_END     (SPI_END),
    .XIP_DIVIDER (XIP_DIVIDER)
  ) i_xip_sequencer (
    .clock     (clock),
    .reset     (reset),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .pstrb_i   (pstrb_i),
    .pready_o  (pready_o),
    .prdata_o  (prdata_o),
    .pslverr_o (pslverr_o),
    .req_o     (reg_req),
    .rsp_i     (reg_rsp)
  );

  // SPI master registers
  spi_regs #(
    .SS_NUM (SS_NUM)
  ) i_spi_regs (
    .clock  (clock),
    .reset  (reset),
    .req_i  (reg_req),
    .rsp_o  (reg_rsp),
    .miso_i (spi_miso_i),
    .sck_o  (spi_sck_o),
    .mosi_o (spi_mosi_o),
    .ss_o   (spi_ss_o),
    .irq_o  (irq_o)
  );

endmodule

/* sim/spi_flash_model.sv */
`timescale 1ns/1ns

module spi_flash_model (
  input  logic sck_i,
  input  logic ss_n_i,
  input  logic mosi_i,
  output logic miso_o
);

  // Command word is opcode then 24-bit address
  logic [31:0] cmd_q = 32'd0;
  int          bit_cnt = 0;
  logic        miso_q = 1'b0;

  // Data bit n of a read starting at cmd address
  function automatic logic read_bit(logic [31:0] cmd, int n);
    logic [23:0] addr;
    logic [7:0]  data;
    addr = cmd[23:0] + 24'(n / 8);
    // Byte content follows the low address byte
    data = addr[7:0] ^ 8'h5A;
    return data[7 - (n % 8)];
  endfunction

  // Mode 0 capture on rising SCK, deselect restarts the frame
  always @(posedge sck_i or posedge ss_n_i) begin
    if (ss_n_i) begin
      bit_cnt <= 0;
      cmd_q   <= 32'd0;
    end else begin
      if (bit_cnt < 32) begin
        cmd_q <= {cmd_q[30:0], mosi_i};
      end
      bit_cnt <= bit_cnt + 1;
    end
  end

  // Next MISO bit on falling SCK
  always @(negedge sck_i or posedge ss_n_i) begin
    if (ss_n_i) begin
      miso_q <= 1'b0;
    end else if (bit_cnt >= 32 && cmd_q[31:24] == 8'h03) begin
      miso_q <= read_bit(cmd_q, bit_cnt - 32);
    end else begin
      // Command phase keeps MISO low
      miso_q <= 1'b0;
    end
  end

  // Held low while deselected
  assign miso_o = ~ss_n_i & miso_q;

endmodule

/* sim/tb_spi_apb.sv */
`timescale 1ns/1ns

module tb_spi_apb
  import spi_pkg::*;
();

  localparam int          CLK_PERIOD = 8;
  localparam int          NTESTS     = 22;
  localparam int          POLL_MAX   = 200;
  localparam logic [31:0] SPI_BASE   = 32'h1000_1000;
  localparam logic [31:0] FLASH_BASE = 32'h3000_0000;
  localparam logic [31:0] STRAY_ADDR = 32'h2000_0000;

  // Test operations
  localparam logic [1:0] OP_WRITE = 2'd0;
  localparam logic [1:0] OP_READ  = 2'd1;
  localparam logic [1:0] OP_POLL  = 2'd2;

  // Pad checks after a test
  localparam logic [2:0] PIN_NONE   = 3'd0;
  localparam logic [2:0] PIN_IDLE   = 3'd1;
  localparam logic [2:0] PIN_QUIET  = 3'd2;
  localparam logic [2:0] PIN_IRQ_HI = 3'd3;
  localparam logic [2:0] PIN_IRQ_LO = 3'd4;

  typedef struct packed {
    logic [1:0]  op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  strb;
    logic [31:0] exp_data;
    logic        exp_err;
    logic [2:0]  pins;
  } test_t;

  logic        clock = 1'b0;
  logic        reset = 1'b1;
  logic [31:0] paddr = 32'd0;
  logic        psel = 1'b0;
  logic        penable = 1'b0;
  logic        pwrite = 1'b0;
  logic [31:0] pwdata = 32'd0;
  logic [3:0]  pstrb = 4'd0;
  logic        pready;
  logic [31:0] prdata;
  logic        pslverr;
  logic        spi_sck;
  logic [7:0]  spi_ss;
  logic        spi_mosi;
  logic        spi_miso;
  logic        irq;

  test_t       tests[NTESTS];
  string       names[NTESTS];
  int          n_tests = 0;
  int          passed = 0;
  int          failed = 0;
  int          sck_edges = 0;
  logic [15:0] lfsr_q = 16'd65;

  always #(CLK_PERIOD / 2) clock = ~clock;

  // Activity monitor for rejected accesses
  always @(posedge spi_sck) sck_edges++;

  spi_apb_top i_spi_apb_top (
    .clock      (clock),
    .reset      (reset),
    .paddr_i    (paddr),
    .psel_i     (psel),
    .penable_i  (penable),
    .pwrite_i   (pwrite),
    .pwdata_i   (pwdata),
    .pstrb_i    (pstrb),
    .pready_o   (pready),
    .prdata_o   (prdata),
    .pslverr_o  (pslverr),
    .spi_sck_o  (spi_sck),
    .spi_ss_o   (spi_ss),
    .spi_mosi_o (spi_mosi),
    .spi_miso_i (spi_miso),
    .irq_o      (irq)
  );

  // Flash sits on select 0
  spi_flash_model i_spi_flash_model (
    .sck_i  (spi_sck),
    .ss_n_i (spi_ss[0]),
    .mosi_i (spi_mosi),
    .miso_o (spi_miso)
  );

  // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit
  task automatic random_bits(input int n, output logic [31:0] val);
    val = 32'd0;
    for (int i = 0; i < n; i++) begin
      val    = {val[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  // APB byte strobe rule
  function automatic logic [31:0] apply_strobes(logic [31:0] old_v, logic [31:0] new_v,
                                                logic [3:0] strb);
    logic [31:0] res;
    res = old_v;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) res[8*i +: 8] = new_v[8*i +: 8];
    end
    return res;
  endfunction

  // Four flash bytes, first byte in the top lane
  function automatic logic [31:0] flash_word(logic [23:0] a);
    logic [31:0] w;
    w = 32'd0;
    for (int k = 0; k < 4; k++) begin
      w[31-8*k -: 8] = (a[7:0] + 8'(k)) ^ 8'h5A;
    end
    return w;
  endfunction

  task automatic add_test(input string name, input logic [1:0] op, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [3:0] strb,
                          input logic [31:0] exp_data, input logic exp_err,
                          input logic [2:0] pins);
    names[n_tests]          = name;
    tests[n_tests].op       = op;
    tests[n_tests].addr     = addr;
    tests[n_tests].wdata    = wdata;
    tests[n_tests].strb     = strb;
    tests[n_tests].exp_data = exp_data;
    tests[n_tests].exp_err  = exp_err;
    tests[n_tests].pins     = pins;
    n_tests++;
  endtask

  task automatic build_table();
    logic [31:0] v0;
    logic [31:0] v1;
    logic [31:0] xa;
    // Register round trip
    random_bits(32, v0);
    add_test("tx0_write", OP_WRITE, SPI_BASE + REG_TX0, v0, 4'hF, 32'd0, 1'b0, PIN_NONE);
    add_test("tx0_read", OP_READ, SPI_BASE + REG_TX0, 32'd0, 4'h0, v0, 1'b0, PIN_NONE);
    random_bits(32, v0);
    random_bits(32, v1);
    add_test("tx1_write", OP_WRITE, SPI_BASE + REG_TX1, v0, 4'hF, 32'd0, 1'b0, PIN_NONE);
    add_test("tx1_write_strb", OP_WRITE, SPI_BASE + REG_TX1, v1, 4'b0101, 32'd0, 1'b0,
             PIN_NONE);
    add_test("tx1_read", OP_READ, SPI_BASE + REG_TX1, 32'd0, 4'h0,
             apply_strobes(v0, v1, 4'b0101), 1'b0, PIN_NONE);
    random_bits(32, v0);
    random_bits(32, v1);
    // DIVIDER keeps 16 bits
    add_test("div_write", OP_WRITE, SPI_BASE + REG_DIVIDER, v0, 4'hF, 32'd0, 1'b0, PIN_NONE);
    add_test("div_write_strb", OP_WRITE, SPI_BASE + REG_DIVIDER, v1, 4'b1110, 32'd0, 1'b0,
             PIN_NONE);
    add_test("div_read", OP_READ, SPI_BASE + REG_DIVIDER, 32'd0, 4'h0,
             apply_strobes(v0, v1, 4'b1110) & 32'h0000_FFFF, 1'b0, PIN_NONE);
    random_bits(32, v0);
    random_bits(32, v1);
    // SS keeps 8 bits, byte 0 masked on the second write
    add_test("ss_write", OP_WRITE, SPI_BASE + REG_SS, v0, 4'hF, 32'd0, 1'b0, PIN_NONE);
    add_test("ss_write_strb", OP_WRITE, SPI_BASE + REG_SS, v1, 4'b1110, 32'd0, 1'b0, PIN_NONE);
    add_test("ss_read", OP_READ, SPI_BASE + REG_SS, 32'd0, 4'h0, v0 & 32'h0000_00FF, 1'b0,
             PIN_NONE);
    // First XIP read
    random_bits(24, xa);
    add_test("xip_read_a", OP_READ, FLASH_BASE + xa, 32'd0, 4'h0, flash_word(xa[23:0]), 1'b0,
             PIN_IDLE);
    // Rejected accesses
    add_test("stray_read", OP_READ, STRAY_ADDR, 32'd0, 4'h0, 32'd0, 1'b1, PIN_QUIET);
    add_test("flash_write", OP_WRITE, FLASH_BASE + 32'h40, 32'hDEAD_BEEF, 4'hF, 32'd0, 1'b1,
             PIN_QUIET);
    // Software 8-bit transfer with interrupt
    random_bits(32, v0);
    add_test("ss_select", OP_WRITE, SPI_BASE + REG_SS, 32'd1, 4'hF, 32'd0, 1'b0, PIN_NONE);
    add_test("div_sw", OP_WRITE, SPI_BASE + REG_DIVIDER, 32'd2, 4'hF, 32'd0, 1'b0, PIN_NONE);
    add_test("tx0_sw", OP_WRITE, SPI_BASE + REG_TX0, v0, 4'hF, 32'd0, 1'b0, PIN_NONE);
    add_test("sw_xfer", OP_POLL, SPI_BASE + REG_CTRL, 32'h0000_1108, 4'hF, 32'h0000_1008, 1'b0,
             PIN_IRQ_HI);
    add_test("rx0_read", OP_READ, SPI_BASE + REG_RX0, 32'd0, 4'h0, 32'd0, 1'b0, PIN_IRQ_HI);
    add_test("ss_deselect", OP_WRITE, SPI_BASE + REG_SS, 32'd0, 4'hF, 32'd0, 1'b0, PIN_IDLE);
    // Interrupt clear, then XIP again
    add_test("irq_clear", OP_WRITE, SPI_BASE + REG_CTRL, 32'h0000_0008, 4'hF, 32'd0, 1'b0,
             PIN_IRQ_LO);
    random_bits(24, xa);
    add_test("xip_read_b", OP_READ, FLASH_BASE + xa, 32'd0, 4'h0, flash_word(xa[23:0]), 1'b0,
             PIN_IDLE);
  endtask

  // Setup, access, wait for pready; inputs move 1 ns after the edge
  task automatic drive_transfer(input logic wr, input logic [31:0] addr,
                                input logic [31:0] wdata, input logic [3:0] strb,
                                output logic [31:0] rdata, output logic err);
    @(posedge clock);
    #1;
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdata;
    pstrb   = strb;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clock);
    #1;
    penable = 1'b1;
    // Sample mid cycle
    @(negedge clock);
    while (!pready) @(negedge clock);
    rdata = prdata;
    err   = pslverr;
    @(posedge clock);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pstrb   = 4'h0;
  endtask

  task automatic apb_write(input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] strb, output logic err);
    logic [31:0] unused_rdata;
    drive_transfer(1'b1, addr, wdata, strb, unused_rdata, err);
  endtask

  task automatic apb_read(input logic [31:0] addr, output logic [31:0] rdata,
                          output logic err);
    drive_transfer(1'b0, addr, 32'd0, 4'h0, rdata, err);
  endtask

  task automatic run_test(input int idx);
    test_t       t;
    logic [31:0] rdata;
    logic        err;
    int          edges0;
    int          polls;
    bit          bad;
    t      = tests[idx];
    bad    = 1'b0;
    rdata  = 32'd0;
    edges0 = sck_edges;
    if (t.op == OP_WRITE) begin
      apb_write(t.addr, t.wdata, t.strb, err);
    end else if (t.op == OP_READ) begin
      apb_read(t.addr, rdata, err);
    end else begin
      // Start through CTRL, then poll go_bsy
      apb_write(t.addr, t.wdata, t.strb, err);
      apb_read(t.addr, rdata, err);
      polls = 1;
      while (rdata[8] && polls < POLL_MAX) begin
        apb_read(t.addr, rdata, err);
        polls++;
      end
      if (rdata[8]) begin
        $display("%s: go_bsy still set after %0d polls", names[idx], polls);
        bad = 1'b1;
      end
    end
    if (err !== t.exp_err) begin
      $display("error %s: pslverr expected %0b actual %0b", names[idx], t.exp_err, err);
      bad = 1'b1;
    end
    if (t.op != OP_WRITE && !t.exp_err && rdata !== t.exp_data) begin
      $display("error %s: data expected %h actual %h", names[idx], t.exp_data, rdata);
      bad = 1'b1;
    end
    if ((t.pins == PIN_IDLE || t.pins == PIN_QUIET) && spi_ss !== 8'hFF) begin
      $display("error %s: spi_ss_o expected ff actual %h", names[idx], spi_ss);
      bad = 1'b1;
    end
    if (t.pins == PIN_QUIET && sck_edges != edges0) begin
      $display("%s: SPI clock ran %0d cycles during a rejected access", names[idx],
               sck_edges - edges0);
      bad = 1'b1;
    end
    if (t.pins == PIN_IRQ_HI && irq !== 1'b1) begin
      $display("error %s: irq_o expected 1 actual %b", names[idx], irq);
      bad = 1'b1;
    end
    if (t.pins == PIN_IRQ_LO && irq !== 1'b0) begin
      $display("error %s: irq_o expected 0 actual %b", names[idx], irq);
      bad = 1'b1;
    end
    if (bad) begin
      failed++;
    end else begin
      passed++;
      $display("ok   %s", names[idx]);
    end
  endtask

  initial begin
    build_table();
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;
    for (int i = 0; i < n_tests; i++) begin
      run_test(i);
    end
    $display("%0d tests, %0d ok, %0d failed", n_tests, passed, failed);
    if (failed == 0 && passed == NTESTS) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Budget of 200 clocks per test
  initial begin
    #(NTESTS * 200 * CLK_PERIOD);
    $display("Watchdog expired after %0d clock periods", NTESTS * 200);
    $display("Checks failed");
    $finish;
  end

endmodule

/* src.f */
hdl/spi_pkg.sv
hdl/spi_shifter.sv
hdl/spi_regs.sv
hdl/xip_sequencer.sv
hdl/spi_apb_top.sv
sim/spi_flash_model.sv
sim/tb_spi_apb.sv

/* Makefile */
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall -Wno-fatal
TOP        = tb_spi_apb
RTL_TOP    = spi_apb_top
FILELIST   = src.f
OBJ_DIR    = obj_dir
PASS_MSG   = All checks passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
